// File: all.f
gmii_pkg.sv
frame_rd_if.sv
tx_frame_buf.sv
crc32_byte.sv
gmii_framer.sv
spi_fanout.sv
gmii_io_top.sv
tb_gmii_io.sv

// File: crc32_byte.sv
`timescale 1ns/1ps

module crc32_byte (
   input  logic            GMII_GTX_CLK_int,
   input  logic            arst_n_i,
   input  logic            clear_i,
   input  logic            update_i,
   input  gmii_pkg::byte_t data_i,
   output gmii_pkg::crc_t  crc_o
);
   import gmii_pkg::*;

   crc_t crc_q;

   // One byte through the reflected CRC, LSB first
   function automatic crc_t crc_next(input crc_t crc, input byte_t data);
      crc_t r;
      r = crc ^ {24'h0, data};
      for (int i = 0; i < 8; i++)
      begin
         if (r[0])
            r = (r >> 1) ^ CRC_POLY;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
         crc_q <= CRC_INIT;
      else if (clear_i)
         crc_q <= CRC_INIT;  // Clear wins over update
      else if (update_i)
         crc_q <= crc_next(crc_q, data_i);
   end

   assign crc_o = crc_q;

endmodule

// File: frame_rd_if.sv
`timescale 1ns/1ps

interface frame_rd_if;
   import gmii_pkg::*;

   buf_addr_t  rd_addr;
   byte_t      rd_data;      // Valid one cycle after rd_en
   frame_len_t wr_seen_len;  // Length of the payload last written
   logic       rd_en;

   modport framer (
      output rd_addr,
      output rd_en,
      input  rd_data,
      input  wr_seen_len
   );

   modport buffer (
      input  rd_addr,
      input  rd_en,
      output rd_data,
      output wr_seen_len
   );

endinterface

// File: gmii_framer.sv
`timescale 1ns/1ps

module gmii_framer (
   input  logic            GMII_GTX_CLK_int,
   input  logic            arst_n_i,
   input  logic            start_i,
   input  logic            abort_i,
   frame_rd_if.framer      rd,
   output gmii_pkg::byte_t txd_o,
   output logic            tx_en_o,
   output logic            tx_er_o,
   output logic            busy_o
);
   import gmii_pkg::*;

   tx_state_t  state_q;
   frame_len_t cnt_q;     // Position within the current phase
   frame_len_t rd_cnt_q;  // Next payload address to read
   frame_len_t len_q;
   logic       start_ok;
   logic       rd_en;
   crc_t       crc;
   crc_t       fcs;

   // Empty buffer means nothing to send
   assign start_ok = start_i && (rd.wr_seen_len != '0);

   // Read one byte ahead of the data phase
   assign rd_en = (state_q == TX_SFD) ||
                  ((state_q == TX_DATA) && (rd_cnt_q < len_q));

   assign rd.rd_en   = rd_en;
   assign rd.rd_addr = rd_cnt_q[7:0];

   crc32_byte crc32_byte_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .clear_i          ((state_q == TX_IDLE) && start_ok),
      .update_i         (state_q == TX_DATA),
      .data_i           (rd.rd_data),
      .crc_o            (crc)
   );

   assign fcs = crc ^ CRC_RESIDUE_XOR;

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q  <= TX_IDLE;
         cnt_q    <= '0;
         rd_cnt_q <= '0;
         len_q    <= '0;
      end
      else
      begin
         if (rd_en)
            rd_cnt_q <= rd_cnt_q + 9'd1;
         case (state_q)
            TX_IDLE:
               if (start_ok)
               begin
                  state_q  <= TX_PREAMBLE;
                  cnt_q    <= '0;
                  rd_cnt_q <= '0;
                  len_q    <= rd.wr_seen_len;  // Length fixed for the frame
               end
            TX_PREAMBLE:
               if (cnt_q == frame_len_t'(PREAMBLE_LEN - 1))
               begin
                  state_q <= TX_SFD;
                  cnt_q   <= '0;
               end
               else
                  cnt_q <= cnt_q + 9'd1;
            TX_SFD:
               state_q <= TX_DATA;
            TX_DATA:
               if (abort_i)
               begin
                  state_q <= TX_IFG;  // No FCS after an abort
                  cnt_q   <= '0;
               end
               else if (cnt_q == len_q - 9'd1)
               begin
                  state_q <= TX_FCS;
                  cnt_q   <= '0;
               end
               else
                  cnt_q <= cnt_q + 9'd1;
            TX_FCS:
               if (cnt_q == 9'd3)
               begin
                  state_q <= TX_IFG;
                  cnt_q   <= '0;
               end
               else
                  cnt_q <= cnt_q + 9'd1;
            TX_IFG:
               if (cnt_q == frame_len_t'(IFG_LEN))  // One more for the pad register delay
               begin
                  state_q <= TX_IDLE;
                  cnt_q   <= '0;
               end
               else
                  cnt_q <= cnt_q + 9'd1;
            default:
               state_q <= TX_IDLE;
         endcase
      end
   end

   always_comb
   begin
      txd_o   = '0;
      tx_en_o = 1'b0;
      case (state_q)
         TX_PREAMBLE:
         begin
            txd_o   = PREAMBLE_BYTE;
            tx_en_o = 1'b1;
         end
         TX_SFD:
         begin
            txd_o   = SFD_BYTE;
            tx_en_o = 1'b1;
         end
         TX_DATA:
         begin
            txd_o   = rd.rd_data;
            tx_en_o = 1'b1;
         end
         TX_FCS:
         begin
            txd_o   = fcs[{cnt_q[1:0], 3'b000} +: 8];  // LSB first
            tx_en_o = 1'b1;
         end
         default:
         begin
            txd_o   = '0;
            tx_en_o = 1'b0;
         end
      endcase
   end

   assign tx_er_o = (state_q == TX_DATA) && abort_i;  // Marks the aborted byte
   assign busy_o  = (state_q != TX_IDLE);

endmodule

// File: gmii_io_top.sv
`timescale 1ns/1ps

module gmii_io_top (
   input  logic                           GMII_GTX_CLK_int,
   input  logic                           arst_n_i,
   input  logic                           wr_en_i,
   input  gmii_pkg::buf_addr_t            wr_addr_i,
   input  gmii_pkg::byte_t                wr_data_i,
   input  logic                           start_i,
   input  logic                           abort_i,
   output gmii_pkg::byte_t                gmii_txd_o,
   output logic                           gmii_tx_en_o,
   output logic                           gmii_tx_er_o,
   output logic                           busy_o,
   input  gmii_pkg::spi_dev_t             spi_sel_i,
   input  logic                           sclk_i,
   input  logic                           mosi_i,
   input  logic [gmii_pkg::SPI_LANES-1:0] sdo_i,
   output logic [gmii_pkg::SPI_LANES-1:0] sen_o,
   output logic [gmii_pkg::SPI_LANES-1:0] sclk_o,
   output logic [gmii_pkg::SPI_LANES-1:0] sdi_o,
   output logic                           miso_o
);
   import gmii_pkg::*;

   byte_t txd_unreg;
   logic  tx_en_unreg;
   logic  tx_er_unreg;

   frame_rd_if rd_if ();

   tx_frame_buf tx_frame_buf_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .wr_en_i          (wr_en_i),
      .wr_addr_i        (wr_addr_i),
      .wr_data_i        (wr_data_i),
      .rd               (rd_if)
   );

   gmii_framer gmii_framer_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .start_i          (start_i),
      .abort_i          (abort_i),
      .rd               (rd_if),
      .txd_o            (txd_unreg),
      .tx_en_o          (tx_en_unreg),
      .tx_er_o          (tx_er_unreg),
      .busy_o           (busy_o)
   );

   spi_fanout spi_fanout_inst (
      .spi_sel_i (spi_sel_i),
      .sclk_i    (sclk_i),
      .mosi_i    (mosi_i),
      .sdo_i     (sdo_i),
      .sen_o     (sen_o),
      .sclk_o    (sclk_o),
      .sdi_o     (sdi_o),
      .miso_o    (miso_o)
   );

   // Pad register stage for the GMII transmit lines
   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         gmii_txd_o   <= '0;
         gmii_tx_en_o <= 1'b0;
         gmii_tx_er_o <= 1'b0;
      end
      else
      begin
         gmii_txd_o   <= txd_unreg;
         gmii_tx_en_o <= tx_en_unreg;
         gmii_tx_er_o <= tx_er_unreg;
      end
   end

endmodule

// File: gmii_pkg.sv
package gmii_pkg;

   // Widths with a meaning of their own
   typedef logic [7:0]  byte_t;
   typedef logic [7:0]  buf_addr_t;
   typedef logic [8:0]  frame_len_t;  // 1 to 256 bytes
   typedef logic [31:0] crc_t;

   localparam int BUF_DEPTH = 256;

   // Ethernet framing
   localparam byte_t PREAMBLE_BYTE = 8'h55;
   localparam int    PREAMBLE_LEN  = 7;
   localparam byte_t SFD_BYTE      = 8'hD5;
   localparam int    IFG_LEN       = 12;    // Idle cycles after each frame

   // Reflected CRC-32 as used for the FCS
   localparam crc_t CRC_INIT        = 32'hFFFF_FFFF;
   localparam crc_t CRC_POLY        = 32'hEDB8_8320;
   localparam crc_t CRC_RESIDUE_XOR = 32'hFFFF_FFFF;

   localparam int SPI_LANES = 4;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_DATA,
      TX_FCS,
      TX_IFG
   } tx_state_t;

   // Lane of each device is its code minus one
   typedef enum logic [2:0] {
      SPI_NONE,
      SPI_CLKGEN,
      SPI_DAC,
      SPI_TX_DB,
      SPI_RX_DB
   } spi_dev_t;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the GMII transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tb_gmii_io -o tb_gmii_io_sim
./obj_dir/tb_gmii_io_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
   echo "RESULT: PASS"
   exit 0
else
   echo "RESULT: FAIL"
   exit 1
fi

// File: spi_fanout.sv
`timescale 1ns/1ps

module spi_fanout (
   input  gmii_pkg::spi_dev_t                spi_sel_i,
   input  logic                              sclk_i,
   input  logic                              mosi_i,
   input  logic [gmii_pkg::SPI_LANES-1:0]    sdo_i,
   output logic [gmii_pkg::SPI_LANES-1:0]    sen_o,
   output logic [gmii_pkg::SPI_LANES-1:0]    sclk_o,
   output logic [gmii_pkg::SPI_LANES-1:0]    sdi_o,
   output logic                              miso_o
);
   import gmii_pkg::*;

   logic [SPI_LANES-1:0] lane_sel;

   // One lane per device, none for SPI_NONE
   always_comb
   begin
      lane_sel = '0;
      case (spi_sel_i)
         SPI_CLKGEN: lane_sel = 4'b0001;
         SPI_DAC:    lane_sel = 4'b0010;
         SPI_TX_DB:  lane_sel = 4'b0100;
         SPI_RX_DB:  lane_sel = 4'b1000;
         default:    lane_sel = '0;
      endcase
   end

   assign sen_o = ~lane_sel;  // Active low enables

   // Unselected lanes held at zero
   assign sclk_o = ~sen_o & {SPI_LANES{sclk_i}};
   assign sdi_o  = ~sen_o & {SPI_LANES{mosi_i}};

   // Only enabled devices drive the shared MISO
   assign miso_o = |(~sen_o & sdo_i);

endmodule

// File: tb_gmii_io.sv
`timescale 1ns/1ps

module tb_gmii_io;
   import gmii_pkg::*;

   localparam int CLK_PERIOD    = 40;
   localparam int RISE_TIMEOUT  = 16;
   localparam int FRAME_TIMEOUT = 400;
   localparam int IDLE_TIMEOUT  = 64;
   localparam int ABORT_IDX     = 5;   // Payload byte that carries tx_er

   logic                 GMII_GTX_CLK_int;
   logic                 arst_n_i;
   logic                 wr_en_i;
   buf_addr_t            wr_addr_i;
   byte_t                wr_data_i;
   logic                 start_i;
   logic                 abort_i;
   byte_t                gmii_txd_o;
   logic                 gmii_tx_en_o;
   logic                 gmii_tx_er_o;
   logic                 busy_o;
   spi_dev_t             spi_sel_i;
   logic                 sclk_i;
   logic                 mosi_i;
   logic [SPI_LANES-1:0] sdo_i;
   logic [SPI_LANES-1:0] sen_o;
   logic [SPI_LANES-1:0] sclk_o;
   logic [SPI_LANES-1:0] sdi_o;
   logic                 miso_o;

   integer seed;
   int     errors;
   int     checks;
   int     rise_cycles;   // Negedges from start_i to the first tx_en sample
   byte_t  payload[$];
   byte_t  cap_data[$];
   logic   cap_er[$];

   gmii_io_top gmii_io_top_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .wr_en_i          (wr_en_i),
      .wr_addr_i        (wr_addr_i),
      .wr_data_i        (wr_data_i),
      .start_i          (start_i),
      .abort_i          (abort_i),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o),
      .gmii_tx_er_o     (gmii_tx_er_o),
      .busy_o           (busy_o),
      .spi_sel_i        (spi_sel_i),
      .sclk_i           (sclk_i),
      .mosi_i           (mosi_i),
      .sdo_i            (sdo_i),
      .sen_o            (sen_o),
      .sclk_o           (sclk_o),
      .sdi_o            (sdi_o),
      .miso_o           (miso_o)
   );

   initial
   begin
      GMII_GTX_CLK_int = 1'b0;
      forever #(CLK_PERIOD / 2) GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
   end

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("ERR %s: expected %02h, actual %02h", name, exp, act);
      end
   endtask

   task automatic check_crc(input string name, input crc_t exp, input crc_t act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("ERR %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("ERR %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_lanes(input string name, input logic [SPI_LANES-1:0] exp,
                              input logic [SPI_LANES-1:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("ERR %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      checks++;
      if (exp != act)
      begin
         errors++;
         $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("%s", what);
   endtask

   // Bit-serial reflected CRC-32 with the final inversion
   function automatic crc_t ref_fcs(input byte_t bytes[$]);
      crc_t c;
      logic fb;
      c = CRC_INIT;
      foreach (bytes[i])
      begin
         for (int b = 0; b < 8; b++)
         begin
            fb = c[0] ^ bytes[i][b];
            c  = c >> 1;
            if (fb)
               c = c ^ CRC_POLY;
         end
      end
      return c ^ CRC_RESIDUE_XOR;
   endfunction

   // Expected byte at a position of the frame before the FCS
   function automatic byte_t frame_byte(input int i);
      if (i < PREAMBLE_LEN)
         return PREAMBLE_BYTE;
      else if (i == PREAMBLE_LEN)
         return SFD_BYTE;
      return payload[i - PREAMBLE_LEN - 1];
   endfunction

   task automatic write_payload(input int len);
      int rnd;
      payload.delete();
      for (int i = 0; i < len; i++)
      begin
         rnd = $random(seed);
         @(negedge GMII_GTX_CLK_int);
         wr_en_i   = 1'b1;
         wr_addr_i = buf_addr_t'(i);
         wr_data_i = rnd[7:0];
         payload.push_back(rnd[7:0]);
      end
      @(negedge GMII_GTX_CLK_int);
      wr_en_i = 1'b0;
   endtask

   // Pulses start_i and records one frame with an optional abort or restart
   task automatic send_and_capture(input int abort_after, input int restart_after);
      int waited;
      int guard;
      cap_data.delete();
      cap_er.delete();
      waited = 0;
      guard  = 0;
      @(negedge GMII_GTX_CLK_int);
      start_i = 1'b1;
      while (!gmii_tx_en_o && waited < RISE_TIMEOUT)
      begin
         @(negedge GMII_GTX_CLK_int);
         start_i = 1'b0;
         waited++;
      end
      rise_cycles = waited;
      if (!gmii_tx_en_o)
         note_failure("Timeout: gmii_tx_en_o never rose after start_i");
      else
      begin
         while (gmii_tx_en_o && guard < FRAME_TIMEOUT)
         begin
            cap_data.push_back(gmii_txd_o);
            cap_er.push_back(gmii_tx_er_o);
            if (cap_data.size() - 1 == abort_after)
               abort_i = 1'b1;
            if (cap_data.size() - 1 == restart_after)
               start_i = 1'b1;
            @(negedge GMII_GTX_CLK_int);
            abort_i = 1'b0;
            start_i = 1'b0;
            guard++;
         end
         if (gmii_tx_en_o)
            note_failure("Timeout: gmii_tx_en_o stayed high, frame never ended");
      end
   endtask

   task automatic wait_idle(input string name);
      int n;
      n = 0;
      while (busy_o && n < IDLE_TIMEOUT)
      begin
         @(negedge GMII_GTX_CLK_int);
         n++;
      end
      if (busy_o)
         note_failure({"Timeout: busy_o never fell in test ", name});
   endtask

   task automatic compare_frame(input string name, input int len);
      int   n;
      crc_t cap_fcs;
      n = PREAMBLE_LEN + 1 + len;
      check_count({name, " tx_en cycles"}, n + 4, cap_data.size());
      if (cap_data.size() == n + 4)
      begin
         for (int i = 0; i < n; i++)
            check_byte($sformatf("%s byte %0d", name, i), frame_byte(i), cap_data[i]);
         cap_fcs = {cap_data[n + 3], cap_data[n + 2], cap_data[n + 1], cap_data[n]};
         check_crc({name, " fcs"}, ref_fcs(payload), cap_fcs);
         for (int i = 0; i < n + 4; i++)
            check_bit($sformatf("%s tx_er %0d", name, i), 1'b0, cap_er[i]);
      end
   endtask

   task automatic test_reset();
      repeat (3)
      begin
         @(negedge GMII_GTX_CLK_int);
         check_bit("reset tx_en", 1'b0, gmii_tx_en_o);
         check_bit("reset tx_er", 1'b0, gmii_tx_er_o);
         check_byte("reset txd", 8'h00, gmii_txd_o);
         check_bit("reset busy", 1'b0, busy_o);
      end
   endtask

   task automatic test_crc_model();
      byte_t digits[$];
      for (int i = 0; i < 9; i++)
         digits.push_back(byte_t'(8'h31 + i));  // ASCII 1 to 9
      check_crc("crc model", 32'hCBF4_3926, ref_fcs(digits));
   endtask

   task automatic test_single_frame();
      write_payload(16);
      send_and_capture(-1, -1);
      check_count("single start to tx_en", 2, rise_cycles);  // Framer plus pad register
      compare_frame("single", 16);
      wait_idle("single");
   endtask

   task automatic test_back_to_back();
      int gap;
      write_payload(40);
      send_and_capture(-1, 10);  // Second start lands mid frame
      compare_frame("b2b first", 40);
      gap = 0;
      while (busy_o && gap < IDLE_TIMEOUT)
      begin
         check_bit("b2b tx_en in ifg", 1'b0, gmii_tx_en_o);
         gap++;
         @(negedge GMII_GTX_CLK_int);
      end
      if (busy_o)
         note_failure("Timeout: busy_o never fell after the first frame");
      check_count("b2b ifg cycles", IFG_LEN, gap);
      repeat (4)
      begin
         @(negedge GMII_GTX_CLK_int);
         check_bit("b2b no second frame", 1'b0, gmii_tx_en_o);
         check_bit("b2b stays idle", 1'b0, busy_o);
      end
      write_payload(1);
      send_and_capture(-1, -1);
      compare_frame("b2b one byte", 1);
      wait_idle("b2b");
   endtask

   task automatic test_abort();
      int n;
      write_payload(20);
      send_and_capture(PREAMBLE_LEN + ABORT_IDX, -1);
      n = PREAMBLE_LEN + 1 + ABORT_IDX + 1;
      check_count("abort tx_en cycles", n, cap_data.size());
      if (cap_data.size() == n)
      begin
         for (int i = 0; i < n; i++)
         begin
            check_byte($sformatf("abort byte %0d", i), frame_byte(i), cap_data[i]);
            check_bit($sformatf("abort tx_er %0d", i), i == n - 1, cap_er[i]);
         end
      end
      wait_idle("abort");
   endtask

   task automatic test_spi();
      spi_dev_t             dev;
      logic [SPI_LANES-1:0] exp_sel;
      int                   rnd;
      dev = dev.first();
      repeat (dev.num())
      begin
         exp_sel = '0;
         if (dev != SPI_NONE)
            exp_sel = 4'b0001 << (int'(dev) - 1);  // CLKGEN is lane 0
         for (int it = 0; it < 4; it++)
         begin
            rnd = $random(seed);
            @(negedge GMII_GTX_CLK_int);
            spi_sel_i = dev;
            sclk_i    = it[0];
            mosi_i    = it[1];
            sdo_i     = rnd[SPI_LANES-1:0];
            @(posedge GMII_GTX_CLK_int);
            check_lanes({"spi ", dev.name(), " sen"}, ~exp_sel, sen_o);
            check_lanes({"spi ", dev.name(), " sclk"}, sclk_i ? exp_sel : '0, sclk_o);
            check_lanes({"spi ", dev.name(), " sdi"}, mosi_i ? exp_sel : '0, sdi_o);
            check_bit({"spi ", dev.name(), " miso"}, |(exp_sel & sdo_i), miso_o);
         end
         dev = dev.next();
      end
   endtask

   initial
   begin
      seed      = 32'hbfa3e065;
      errors    = 0;
      checks    = 0;
      arst_n_i  = 1'b0;
      wr_en_i   = 1'b0;
      wr_addr_i = '0;
      wr_data_i = '0;
      start_i   = 1'b0;
      abort_i   = 1'b0;
      spi_sel_i = SPI_NONE;
      sclk_i    = 1'b0;
      mosi_i    = 1'b0;
      sdo_i     = '0;
      repeat (3) @(posedge GMII_GTX_CLK_int);
      @(negedge GMII_GTX_CLK_int);
      arst_n_i = 1'b1;

      test_reset();
      test_crc_model();
      test_single_frame();
      test_back_to_back();
      test_abort();
      test_spi();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: tx_frame_buf.sv
`timescale 1ns/1ps

module tx_frame_buf (
   input  logic                GMII_GTX_CLK_int,
   input  logic                arst_n_i,
   input  logic                wr_en_i,
   input  gmii_pkg::buf_addr_t wr_addr_i,
   input  gmii_pkg::byte_t     wr_data_i,
   frame_rd_if.buffer          rd
);
   import gmii_pkg::*;

   byte_t      mem_q [BUF_DEPTH];
   byte_t      rd_data_q;
   frame_len_t len_q;
   frame_len_t wr_len;
   logic       fresh_q;  // Payload was read, next write starts a new one

   assign wr_len = frame_len_t'(wr_addr_i) + 9'd1;

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (wr_en_i)
         mem_q[wr_addr_i] <= wr_data_i;
      if (rd.rd_en)
         rd_data_q <= mem_q[rd.rd_addr];  // Registered read
   end

   // High-water mark of the current payload
   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         len_q   <= '0;
         fresh_q <= 1'b0;
      end
      else if (wr_en_i)
      begin
         fresh_q <= 1'b0;
         if (fresh_q || (wr_len > len_q))
            len_q <= wr_len;
      end
      else if (rd.rd_en)
         fresh_q <= 1'b1;
   end

   assign rd.rd_data     = rd_data_q;
   assign rd.wr_seen_len = len_q;

endmodule
